//--- term_pkg.sv
package term_pkg;

	// Screen geometry
	localparam int unsigned console_lines   = 24;
	localparam int unsigned console_columns = 80;
	localparam int unsigned tab_width       = 8;    // HT stops every 8 columns

	// 24 x 80 = 1920 cells
	localparam int unsigned buf_addr_w = 11;

	// Control and printable bounds of the byte stream
	localparam logic [7:0] chr_bs    = 8'h08;
	localparam logic [7:0] chr_ht    = 8'h09;
	localparam logic [7:0] chr_lf    = 8'h0A;
	localparam logic [7:0] chr_vt    = 8'h0B;
	localparam logic [7:0] chr_ff    = 8'h0C;
	localparam logic [7:0] chr_cr    = 8'h0D;
	localparam logic [7:0] chr_esc   = 8'h1B;
	localparam logic [7:0] chr_space = 8'h20;   // First printable
	localparam logic [7:0] chr_tilde = 8'h7E;   // Last printable

	// Decoded commands from the parser
	typedef enum logic [3:0] {
		CMD_NONE,
		CUP,    // Cursor position
		CUF,    // Cursor forward
		CUB,    // Cursor backward
		CUD,    // Cursor down
		CUU,    // Cursor up
		IND,    // Index
		RI,     // Reverse index
		NEL,    // Next line
		INPUT   // Plain byte, printable or control
	} cmd_e;

	// Numeric parameters plus the raw byte
	typedef struct packed {
		logic [7:0] pn1;
		logic [7:0] pn2;
		logic [7:0] pchar;
	} param_t;

	// Zero-based cursor position
	typedef struct packed {
		logic [7:0] line;   // 0 to 23
		logic [7:0] col;    // 0 to 79
	} cursor_t;

endpackage

//--- term_cmd_if.sv
interface term_cmd_if;
	import term_pkg::*;

	logic   cmd_valid;  // One-cycle strobe
	cmd_e   cmd_type;
	param_t cmd_param;

	// Parser side
	modport src (
		output cmd_valid,
		output cmd_type,
		output cmd_param
	);

	// Cursor control and screen buffer side
	modport dst (
		input cmd_valid,
		input cmd_type,
		input cmd_param
	);

endinterface

//--- esc_parser.sv
module esc_parser (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_byte_valid,
	input  logic [7:0] i_byte,
	term_cmd_if.src    o_cmd
);
	import term_pkg::*;

	typedef enum logic [1:0] {
		ST_GROUND,
		ST_ESC,
		ST_CSI
	} state_e;

	state_e      state;
	state_e      state_nxt;
	logic        param_sel;     // Set after ';', selects pn2
	logic [7:0]  pn1;
	logic [7:0]  pn2;
	logic        is_digit;
	logic        is_sep;
	logic [7:0]  acc_cur;
	logic [11:0] acc_wide;
	logic [7:0]  acc_sat;
	logic        emit;
	cmd_e        emit_type;

	assign is_digit = (i_byte >= 8'h30) && (i_byte <= 8'h39);
	assign is_sep   = (i_byte == 8'h3B);   // ';'

	// Decimal accumulation, saturating at 255
	assign acc_cur  = param_sel ? pn2 : pn1;
	assign acc_wide = {4'd0, acc_cur} * 12'd10 + {8'd0, i_byte[3:0]};
	assign acc_sat  = (acc_wide > 12'd255) ? 8'hFF : acc_wide[7:0];

	assign emit = (emit_type != CMD_NONE);

	always_comb
	begin
		state_nxt = state;
		emit_type = CMD_NONE;
		case (state)
			ST_GROUND:
			begin
				if (i_byte == chr_esc)
					state_nxt = ST_ESC;
				else
					emit_type = INPUT;
			end
			ST_ESC:
			begin
				state_nxt = ST_GROUND;
				case (i_byte)
					8'h5B: state_nxt = ST_CSI;    // '['
					8'h44: emit_type = IND;       // 'D'
					8'h4D: emit_type = RI;        // 'M'
					8'h45: emit_type = NEL;       // 'E'
					default: emit_type = CMD_NONE;
				endcase
			end
			ST_CSI:
			begin
				// Digits and ';' keep collecting, anything else is final
				if (!is_digit && !is_sep)
				begin
					state_nxt = ST_GROUND;
					case (i_byte)
						8'h48, 8'h66: emit_type = CUP;   // 'H' or 'f'
						8'h43: emit_type = CUF;          // 'C'
						8'h44: emit_type = CUB;          // 'D'
						8'h42: emit_type = CUD;          // 'B'
						8'h41: emit_type = CUU;          // 'A'
						default: emit_type = CMD_NONE;   // Unknown final byte
					endcase
				end
			end
			default: state_nxt = ST_GROUND;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state           <= ST_GROUND;
			param_sel       <= 1'b0;
			o_cmd.cmd_valid <= 1'b0;
		end
		else
		begin
			o_cmd.cmd_valid <= i_byte_valid && emit;
			if (i_byte_valid)
			begin
				state <= state_nxt;
				if (state == ST_ESC)
					param_sel <= 1'b0;
				else if ((state == ST_CSI) && is_sep)
					param_sel <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_byte_valid)
		begin
			if ((state == ST_ESC) && (state_nxt == ST_CSI))
			begin
				pn1 <= 8'd0;
				pn2 <= 8'd0;
			end
			else if ((state == ST_CSI) && is_digit)
			begin
				if (param_sel)
					pn2 <= acc_sat;
				else
					pn1 <= acc_sat;
			end

			if (emit)
			begin
				o_cmd.cmd_type  <= emit_type;
				o_cmd.cmd_param <= '{pn1: pn1, pn2: pn2, pchar: i_byte};
			end
		end
	end

endmodule

//--- cursor_control.sv
module cursor_control (
	input  logic              clk,
	input  logic              rst,
	term_cmd_if.dst           i_cmd,
	output term_pkg::cursor_t o_cursor
);
	import term_pkg::*;

	logic [7:0] pn1;
	logic [7:0] pn2;
	logic [7:0] pchar;
	logic [7:0] count;
	logic [7:0] cup_line;
	logic [7:0] cup_col;
	logic [8:0] tab_stop;
	logic [7:0] tab_col;
	cursor_t    cursor_nxt;

	// Move towards the far edge, stopping on the last position
	function automatic logic [7:0] move_fwd(input logic [7:0] pos, input logic [7:0] cnt,
		input logic [7:0] size);
		logic [8:0] sum;
		sum = {1'b0, pos} + {1'b0, cnt};
		return (sum >= {1'b0, size}) ? size - 8'd1 : sum[7:0];
	endfunction

	// Move towards position 0, stopping there
	function automatic logic [7:0] move_back(input logic [7:0] pos, input logic [7:0] cnt);
		return (pos < cnt) ? 8'd0 : pos - cnt;
	endfunction

	assign pn1   = i_cmd.cmd_param.pn1;
	assign pn2   = i_cmd.cmd_param.pn2;
	assign pchar = i_cmd.cmd_param.pchar;

	assign count    = (pn1 == 8'd0) ? 8'd1 : pn1;   // Count of 0 means 1
	// CUP parameters are one-based, 0 and 1 both mean the first
	assign cup_line = move_fwd(8'd0, (pn1 == 8'd0) ? 8'd0 : pn1 - 8'd1, 8'(console_lines));
	assign cup_col  = move_fwd(8'd0, (pn2 == 8'd0) ? 8'd0 : pn2 - 8'd1, 8'(console_columns));

	// Next multiple of the tab width
	assign tab_stop = {1'b0, o_cursor.col} + 9'(tab_width) - 9'(o_cursor.col % tab_width);
	assign tab_col  = (tab_stop >= 9'(console_columns)) ? 8'(console_columns - 1) : tab_stop[7:0];

	always_comb
	begin
		cursor_nxt = o_cursor;
		case (i_cmd.cmd_type)
			CUP:
			begin
				cursor_nxt.line = cup_line;
				cursor_nxt.col  = cup_col;
			end
			CUF: cursor_nxt.col  = move_fwd(o_cursor.col, count, 8'(console_columns));
			CUB: cursor_nxt.col  = move_back(o_cursor.col, count);
			CUD: cursor_nxt.line = move_fwd(o_cursor.line, count, 8'(console_lines));
			CUU: cursor_nxt.line = move_back(o_cursor.line, count);
			IND: cursor_nxt.line = move_fwd(o_cursor.line, 8'd1, 8'(console_lines));
			RI:  cursor_nxt.line = move_back(o_cursor.line, 8'd1);
			NEL:
			begin
				cursor_nxt.line = move_fwd(o_cursor.line, 8'd1, 8'(console_lines));
				cursor_nxt.col  = 8'd0;
			end
			INPUT:
			begin
				case (pchar)
					chr_lf, chr_vt, chr_ff:
						cursor_nxt.line = move_fwd(o_cursor.line, 8'd1, 8'(console_lines));
					chr_cr: cursor_nxt.col = 8'd0;
					chr_bs: cursor_nxt.col = move_back(o_cursor.col, 8'd1);
					chr_ht: cursor_nxt.col = tab_col;
					default:
					begin
						// Printing in the last column leaves the cursor there
						if (pchar >= chr_space)
							cursor_nxt.col = move_fwd(o_cursor.col, 8'd1, 8'(console_columns));
					end
				endcase
			end
			default: cursor_nxt = o_cursor;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			o_cursor <= '0;
		else if (i_cmd.cmd_valid)
			o_cursor <= cursor_nxt;
	end

endmodule

//--- screen_buffer.sv
module screen_buffer (
	input  logic              clk,
	input  logic              rst,
	term_cmd_if.dst           i_cmd,
	input  term_pkg::cursor_t i_cursor,
	input  logic [7:0]        i_rd_line,
	input  logic [7:0]        i_rd_col,
	output logic [7:0]        o_rd_char
);
	import term_pkg::*;

	logic [7:0]            mem [console_lines * console_columns];
	logic [buf_addr_w-1:0] wr_addr;
	logic [buf_addr_w-1:0] rd_addr;
	logic [7:0]            wr_char;
	logic                  wr_en;
	logic                  rd_in_range;

	// Row-major cell index
	function automatic logic [buf_addr_w-1:0] cell_addr(input logic [7:0] line,
		input logic [7:0] col);
		return buf_addr_w'(line) * buf_addr_w'(console_columns) + buf_addr_w'(col);
	endfunction

	assign wr_char = i_cmd.cmd_param.pchar;
	// Only printable input lands in the buffer
	assign wr_en   = i_cmd.cmd_valid && (i_cmd.cmd_type == INPUT)
		&& (wr_char >= chr_space) && (wr_char <= chr_tilde);
	// Cursor before this command's update
	assign wr_addr = cell_addr(i_cursor.line, i_cursor.col);

	assign rd_in_range = (i_rd_line < 8'(console_lines)) && (i_rd_col < 8'(console_columns));
	assign rd_addr     = cell_addr(i_rd_line, i_rd_col);

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_char;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			o_rd_char <= 8'd0;
		else if (rd_in_range)
			o_rd_char <= mem[rd_addr];
		else
			o_rd_char <= 8'd0;   // Off-screen reads give 0
	end

endmodule

//--- vt_console_top.sv
module vt_console_top (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_byte_valid,
	input  logic [7:0] i_byte,
	input  logic [7:0] i_rd_line,
	input  logic [7:0] i_rd_col,
	output logic [7:0] o_cursor_line,
	output logic [7:0] o_cursor_col,
	output logic [7:0] o_rd_char
);
	import term_pkg::*;

	cursor_t cursor;    // Current position, feeds the buffer write address

	// Decoded commands, one per strobe
	term_cmd_if cmd_bus ();

	esc_parser u_parser (
		.clk          (clk),
		.rst          (rst),
		.i_byte_valid (i_byte_valid),
		.i_byte       (i_byte),
		.o_cmd        (cmd_bus.src)
	);

	cursor_control u_cursor (
		.clk      (clk),
		.rst      (rst),
		.i_cmd    (cmd_bus.dst),
		.o_cursor (cursor)
	);

	screen_buffer u_screen (
		.clk       (clk),
		.rst       (rst),
		.i_cmd     (cmd_bus.dst),
		.i_cursor  (cursor),
		.i_rd_line (i_rd_line),
		.i_rd_col  (i_rd_col),
		.o_rd_char (o_rd_char)
	);

	assign o_cursor_line = cursor.line;
	assign o_cursor_col  = cursor.col;

endmodule

//--- tb_vt_console.sv
module tb_vt_console;
	import term_pkg::*;

	localparam int settle_cycles = 3;   // Byte to cursor outputs plus margin
	localparam int wait_limit    = 64;

	logic       clk = 1'b0;
	logic       rst;
	logic       i_byte_valid;
	logic [7:0] i_byte;
	logic [7:0] i_rd_line;
	logic [7:0] i_rd_col;
	wire  [7:0] o_cursor_line;
	wire  [7:0] o_cursor_col;
	wire  [7:0] o_rd_char;

	integer     seed;
	int         exp_line;   // Model cursor
	int         exp_col;
	logic [7:0] shadow [console_lines * console_columns];
	int         wr_log [$];   // Cell indices in write order

	vt_console_top dut0 (
		.clk           (clk),
		.rst           (rst),
		.i_byte_valid  (i_byte_valid),
		.i_byte        (i_byte),
		.i_rd_line     (i_rd_line),
		.i_rd_col      (i_rd_col),
		.o_cursor_line (o_cursor_line),
		.o_cursor_col  (o_cursor_col),
		.o_rd_char     (o_rd_char)
	);

	always #2 clk = ~clk;

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	// Bounded count of falling edges
	task automatic wait_cycles(input int n);
		int i;
		if (n > wait_limit)
		begin
			$display("A wait of %0d cycles is longer than the allowed %0d", n, wait_limit);
			stop_run();
		end
		for (i = 0; i < n; i++)
			@(negedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b);
		i_byte_valid = 1'b1;
		i_byte       = b;
		@(negedge clk);
		i_byte_valid = 1'b0;
	endtask

	task automatic send_str(input string s);
		int i;
		for (i = 0; i < s.len(); i++)
			send_byte(s[i]);
	endtask

	task automatic csi(input string params, input logic [7:0] fin);
		send_byte(8'h1B);
		send_byte("[");
		send_str(params);
		send_byte(fin);
	endtask

	task automatic esc(input logic [7:0] b);
		send_byte(8'h1B);
		send_byte(b);
	endtask

	function automatic int bound(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	function automatic int count_of(input int n);
		return (n == 0) ? 1 : n;   // Zero count means one
	endfunction

	task automatic model_move(input int dl, input int dc);
		exp_line = bound(exp_line + dl, 0, console_lines - 1);
		exp_col  = bound(exp_col + dc, 0, console_columns - 1);
	endtask

	task automatic model_cup(input int pn1, input int pn2);
		exp_line = bound(pn1 - 1, 0, console_lines - 1);
		exp_col  = bound(pn2 - 1, 0, console_columns - 1);
	endtask

	task automatic model_nel();
		model_move(1, 0);
		exp_col = 0;
	endtask

	// Ground-state byte of either kind
	task automatic model_byte(input logic [7:0] b);
		int addr;
		case (b)
			8'h0A, 8'h0B, 8'h0C: model_move(1, 0);
			8'h0D: exp_col = 0;
			8'h08: model_move(0, -1);
			8'h09: exp_col = bound((exp_col / tab_width + 1) * tab_width, 0, console_columns - 1);
			default:
			begin
				if (b >= 8'h20)
				begin
					if (b <= 8'h7E)
					begin
						addr = exp_line * console_columns + exp_col;
						shadow[addr] = b;
						wr_log.push_back(addr);
					end
					model_move(0, 1);   // Sticks at the last column
				end
			end
		endcase
	endtask

	task automatic type_byte(input logic [7:0] b);
		send_byte(b);
		model_byte(b);
	endtask

	task automatic type_str(input string s);
		int i;
		for (i = 0; i < s.len(); i++)
			type_byte(s[i]);
	endtask

	task automatic check_cursor();
		wait_cycles(settle_cycles);
		check_eq("o_cursor_line", exp_line, o_cursor_line);
		check_eq("o_cursor_col", exp_col, o_cursor_col);
	endtask

	task automatic check_cell(input int line, input int col);
		i_rd_line = line;
		i_rd_col  = col;
		wait_cycles(1);   // Registered read port
		check_eq($sformatf("o_rd_char(%0d,%0d)", line, col),
			shadow[line * console_columns + col], o_rd_char);
	endtask

	// Coordinates outside the screen read as 0
	task automatic check_off_screen(input int line, input int col);
		i_rd_line = line;
		i_rd_col  = col;
		wait_cycles(1);
		check_eq($sformatf("o_rd_char(%0d,%0d)", line, col), 0, o_rd_char);
	endtask

	task automatic test_print();
		int i;
		check_cursor();
		type_str("HELLO");
		check_cursor();
		for (i = 0; i < 5; i++)
			check_cell(0, i);
		type_byte(8'h0D);
		type_byte(8'h0A);
		for (i = 0; i < 85; i++)
			type_byte(8'h41 + i % 26);
		check_cursor();
		check_cell(1, 0);
		check_cell(1, 78);
		check_cell(1, 79);
		check_off_screen(24, 0);
		check_off_screen(0, 80);
	endtask

	task automatic test_cup();
		csi("5;10", "H");
		model_cup(5, 10);
		check_cursor();
		csi("", "H");
		model_cup(0, 0);
		check_cursor();
		csi("7;7", "H");
		model_cup(7, 7);
		check_cursor();
		csi("0;0", "f");
		model_cup(0, 0);
		check_cursor();
		csi("99;99", "H");
		model_cup(99, 99);
		check_cursor();
	endtask

	task automatic move_step(input string params, input logic [7:0] fin, input int n,
		input int dl, input int dc);
		csi(params, fin);
		model_move(dl * count_of(n), dc * count_of(n));
		check_cursor();
	endtask

	task automatic test_moves();
		csi("11;41", "H");
		model_cup(11, 41);
		check_cursor();
		move_step("5", "C", 5, 0, 1);
		move_step("", "C", 0, 0, 1);
		move_step("200", "C", 200, 0, 1);
		move_step("3", "D", 3, 0, -1);
		move_step("", "D", 0, 0, -1);
		move_step("999", "D", 255, 0, -1);   // Saturates at 255
		move_step("4", "B", 4, 1, 0);
		move_step("", "B", 0, 1, 0);
		move_step("50", "B", 50, 1, 0);
		move_step("6", "A", 6, -1, 0);
		move_step("0", "A", 0, -1, 0);
		move_step("40", "A", 40, -1, 0);
	endtask

	task automatic test_controls();
		csi("2;1", "H");
		model_cup(2, 1);
		check_cursor();
		type_byte(8'h08);   // BS at column 0
		check_cursor();
		type_byte(8'h09);
		check_cursor();
		type_byte(8'h09);
		check_cursor();
		csi("2;78", "H");
		model_cup(2, 78);
		type_byte(8'h09);   // Clamps to column 79
		check_cursor();
		type_byte(8'h09);
		check_cursor();
		type_byte(8'h0D);
		check_cursor();
		esc("M");
		model_move(-1, 0);
		check_cursor();
		esc("M");   // RI on line 0
		model_move(-1, 0);
		check_cursor();
		esc("D");
		model_move(1, 0);
		check_cursor();
		csi("1;4", "H");
		model_cup(1, 4);
		esc("E");
		model_nel();
		check_cursor();
		csi("24;10", "H");
		model_cup(24, 10);
		type_byte(8'h0A);   // LF on the last line
		check_cursor();
		esc("D");
		model_move(1, 0);
		check_cursor();
		esc("E");
		model_nel();
		check_cursor();
		check_cell(0, 0);
		check_cell(0, 3);
		check_cell(1, 0);
		check_cell(1, 8);
		check_cell(1, 16);
		check_cell(1, 77);
		check_cell(1, 79);
	endtask

	task automatic test_unknown_and_random();
		int         i;
		int         k;
		int         start;
		int         n;
		int         addr;
		logic [7:0] b;
		csi("2;3", "H");
		model_cup(2, 3);
		check_cursor();
		esc("Z");
		csi("5", "z");
		check_cursor();
		check_cell(1, 2);
		start = wr_log.size();
		for (i = 0; i < 200; i++)
		begin
			k = {$random(seed)} % 100;
			if (k < 8)
				b = 8'h0D;
			else if (k < 16)
				b = 8'h0A;
			else if (k < 22)
				b = 8'h08;
			else if (k < 28)
				b = 8'h09;
			else
				b = 8'h20 + {$random(seed)} % 95;
			type_byte(b);
		end
		check_cursor();
		n = wr_log.size() - start;
		if (n == 0)
		begin
			$display("The random phase wrote no printable character to check");
			stop_run();
		end
		for (i = 0; i < 20; i++)
		begin
			addr = wr_log[start + {$random(seed)} % n];
			check_cell(addr / console_columns, addr % console_columns);
		end
	endtask

	initial
	begin
		seed         = 32'h0038b757;
		exp_line     = 0;
		exp_col      = 0;
		rst          = 1'b1;
		i_byte_valid = 1'b0;
		i_byte       = 8'd0;
		i_rd_line    = 8'd0;
		i_rd_col     = 8'd0;
		wait_cycles(3);   // Three rising edges in reset
		rst = 1'b0;
		test_print();
		test_cup();
		test_moves();
		test_controls();
		test_unknown_and_random();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- flist.f
term_pkg.sv
term_cmd_if.sv
esc_parser.sv
cursor_control.sv
screen_buffer.sv
vt_console_top.sv
tb_vt_console.sv

//--- Bender.yml
package:
  name: vt_console

sources:
  - term_pkg.sv
  - term_cmd_if.sv
  - esc_parser.sv
  - cursor_control.sv
  - screen_buffer.sv
  - vt_console_top.sv
  - target: test
    files:
      - tb_vt_console.sv
